// ==== include/coherence_settings.svh ====
// Bus widths and RAM timing. RAM_LATENCY must be 1 or more and addresses wrap inside the RAM depth
`ifndef COHERENCE_SETTINGS_SVH
`define COHERENCE_SETTINGS_SVH

// ##################################################
// Data path
// ##################################################
// Bits per data word
`define WORD_W 32
// Bits per word address
`define ADDR_W 32

// ##################################################
// RAM
// ##################################################
// RAM holds 2**RAM_DEPTH_LOG2 words
`define RAM_DEPTH_LOG2 10
// BUSY cycles before the ACCESS cycle
`define RAM_LATENCY 2

`endif

// ==== source/coherence_pkg.sv ====
// Bus types for exactly two cores. Widths come from the settings header
`include "coherence_settings.svh"

package coherence_pkg;

	typedef logic [`WORD_W-1:0] word_t;
	typedef logic [`ADDR_W-1:0] addr_t;

	typedef enum logic [1:0] {FREE, BUSY, ACCESS} ramstate_t;

	// SNOOPn carries the requesting core in its name
	typedef enum logic [3:0] {
		IDLE,
		WB1, WB2,
		FETCH,
		SNOOP0, SNOOP1,
		LD1, LD2, // Snoop served from RAM
		C2C1, C2C2 // Snoop served by the dirty owner
	} bus_state_t;

	typedef struct packed {
		logic iren;
		addr_t iaddr;
		logic dren;
		logic dwen;
		addr_t daddr;
		word_t dstore;
		logic cctrans;
		logic ccwrite;
	} cache_req_t;

	typedef struct packed {
		logic iwait;
		word_t iload;
		logic dwait;
		word_t dload;
		logic ccwait;
		logic ccinv;
		addr_t ccsnoopaddr;
	} cache_rsp_t;

	typedef struct packed {
		logic ren;
		logic wen;
		addr_t addr;
		word_t store;
	} ram_req_t;

endpackage

// ==== source/fetch_arbiter.sv ====
// Two requesters only. A grant is kept until fetch_done even if its iren drops meanwhile
`timescale 1ns/100ps

module fetch_arbiter (
	input logic CLK,
	input logic nRST,
	input logic [1:0] iren,
	input logic fetch_done,
	output logic fetch_req,
	output logic fetch_sel
);

	logic prio; // Core that wins a tie
	logic granted;
	logic grant_sel;
	logic pick;

	// ##################################################
	// Choice
	// ##################################################
	always_comb
	begin
		if (iren[prio])
			pick = prio;
		else
			pick = ~prio; // Other core, or don't care when idle
	end

	assign fetch_req = granted | (|iren);
	assign fetch_sel = granted ? grant_sel : pick;

	// ##################################################
	// Grant and priority
	// ##################################################
	always_ff @(posedge CLK, negedge nRST)
	begin
		if (!nRST)
		begin
			prio <= 1'b0;
			granted <= 1'b0;
			grant_sel <= 1'b0;
		end
		else if (fetch_done)
		begin
			// Served core loses priority
			prio <= ~fetch_sel;
			granted <= 1'b0;
		end
		else if (!granted && (|iren))
		begin
			granted <= 1'b1;
			grant_sel <= pick;
		end
	end

	// Controller reads iaddr of fetch_sel over several cycles
	assert property (@(posedge CLK) disable iff (!nRST)
		fetch_req && !fetch_done |=> $stable(fetch_sel))
		else $error("fetch_sel moved while a fetch was pending");

endmodule

// ==== source/memory_port.sv ====
// Fixed-latency single-ported RAM without reset contents or error response. Addresses wrap at the depth
`timescale 1ns/100ps
`include "coherence_settings.svh"

module memory_port
	import coherence_pkg::*;
(
	input logic CLK,
	input logic nRST,
	input ram_req_t ram_req,
	output ramstate_t ramstate,
	output word_t ramload
);

	localparam int DEPTH = 1 << `RAM_DEPTH_LOG2;
	localparam int CNT_W = $clog2(`RAM_LATENCY + 1);

	word_t mem [DEPTH];
	logic [CNT_W-1:0] count; // BUSY cycles seen so far
	logic [`RAM_DEPTH_LOG2-1:0] index;
	logic active;

	assign active = ram_req.ren | ram_req.wen;
	assign index = ram_req.addr[`RAM_DEPTH_LOG2-1:0]; // Low bits only

	// ##################################################
	// Latency counter
	// ##################################################
	always_comb
	begin
		if (!active)
			ramstate = FREE;
		else if (count == CNT_W'(`RAM_LATENCY))
			ramstate = ACCESS;
		else
			ramstate = BUSY;
	end

	always_ff @(posedge CLK, negedge nRST)
	begin
		if (!nRST)
			count <= '0;
		else if (!active || (ramstate == ACCESS))
			count <= '0; // Held request starts a fresh access
		else
			count <= count + 1'b1;
	end

	// ##################################################
	// Storage
	// ##################################################
	always_ff @(posedge CLK)
	begin
		if ((ramstate == ACCESS) && ram_req.wen)
			mem[index] <= ram_req.store;
	end

	// Valid for the requester in the ACCESS cycle
	assign ramload = mem[index];

	// Controller must hold the request and its address until ACCESS
	assert property (@(posedge CLK) disable iff (!nRST)
		ramstate == BUSY |=> $stable(ram_req.addr) && active)
		else $error("RAM request changed while BUSY");

endmodule

// ==== source/bus_controller.sv ====
// One transaction at a time with write-back over snoop over fetch. Each block is two words
`timescale 1ns/100ps

module bus_controller
	import coherence_pkg::*;
(
	input logic CLK,
	input logic nRST,
	input cache_req_t [1:0] cache_req,
	output cache_rsp_t [1:0] cache_rsp,
	input logic fetch_req,
	input logic fetch_sel,
	output logic fetch_done,
	output ram_req_t ram_req,
	input ramstate_t ramstate,
	input word_t ramload
);

	bus_state_t state, next_state;
	logic core, core_n; // Writer or snoop requester
	logic other;
	logic access;
	logic snoop_ans;

	assign other = ~core;
	assign access = (ramstate == ACCESS);
	assign snoop_ans = ((state == SNOOP0) || (state == SNOOP1)) && cache_req[other].cctrans;

	always_ff @(posedge CLK, negedge nRST)
	begin
		if (!nRST)
		begin
			state <= IDLE;
			core <= 1'b0;
		end
		else
		begin
			state <= next_state;
			core <= core_n;
		end
	end

	// ##################################################
	// Next state
	// ##################################################
	always_comb
	begin : next_logic
		next_state = state;
		core_n = core;
		case (state)
			IDLE:
			begin
				if (cache_req[0].dwen || cache_req[1].dwen)
				begin
					next_state = WB1;
					core_n = ~cache_req[0].dwen; // Core 0 first on a tie
				end
				else if (cache_req[0].cctrans && cache_req[0].dren)
				begin
					next_state = SNOOP0;
					core_n = 1'b0;
				end
				else if (cache_req[1].cctrans && cache_req[1].dren)
				begin
					next_state = SNOOP1;
					core_n = 1'b1;
				end
				else if (fetch_req)
					next_state = FETCH;
			end
			WB1:
				if (access) next_state = WB2;
			WB2:
				if (access) next_state = IDLE;
			FETCH:
				if (access) next_state = IDLE;
			SNOOP0, SNOOP1:
			begin
				// Owner with a dirty copy supplies the data itself
				if (snoop_ans)
					next_state = cache_req[other].ccwrite ? C2C1 : LD1;
			end
			LD1:
				if (access) next_state = LD2;
			LD2:
				if (access) next_state = IDLE;
			C2C1:
				if (access) next_state = C2C2;
			C2C2:
				if (access) next_state = IDLE;
			default:
				next_state = IDLE;
		endcase
	end

	// ##################################################
	// Outputs
	// ##################################################
	always_comb
	begin : output_logic
		for (int i = 0; i < 2; i++)
		begin
			cache_rsp[i].iwait = 1'b1;
			cache_rsp[i].iload = '0;
			cache_rsp[i].dwait = 1'b1;
			cache_rsp[i].dload = '0;
			cache_rsp[i].ccwait = 1'b0;
			cache_rsp[i].ccinv = cache_req[1-i].ccwrite; // Other core is writing
			cache_rsp[i].ccsnoopaddr = '0;
		end
		ram_req = '0;
		fetch_done = 1'b0;

		case (state)
			WB1, WB2:
			begin
				ram_req.wen = 1'b1;
				ram_req.addr = cache_req[core].daddr;
				ram_req.store = cache_req[core].dstore;
				cache_rsp[core].dwait = ~access;
				cache_rsp[other].ccwait = 1'b1;
			end
			FETCH:
			begin
				ram_req.ren = 1'b1;
				ram_req.addr = cache_req[fetch_sel].iaddr;
				cache_rsp[fetch_sel].iwait = ~access;
				cache_rsp[fetch_sel].iload = ramload;
				fetch_done = access;
			end
			SNOOP0, SNOOP1:
			begin
				cache_rsp[other].ccwait = 1'b1;
				cache_rsp[other].ccsnoopaddr = cache_req[core].daddr;
			end
			LD1, LD2:
			begin
				ram_req.ren = 1'b1;
				ram_req.addr = cache_req[core].daddr;
				cache_rsp[core].dwait = ~access;
				cache_rsp[core].dload = ramload;
				cache_rsp[other].ccwait = 1'b1;
				cache_rsp[other].ccsnoopaddr = cache_req[core].daddr;
			end
			C2C1, C2C2:
			begin
				// Owner word goes to RAM and to the requester together
				ram_req.wen = 1'b1;
				ram_req.addr = cache_req[other].daddr;
				ram_req.store = cache_req[other].dstore;
				cache_rsp[core].dwait = ~access;
				cache_rsp[core].dload = cache_req[other].dstore;
				cache_rsp[other].dwait = ~access;
				cache_rsp[other].ccwait = 1'b1;
				cache_rsp[other].ccsnoopaddr = cache_req[core].daddr;
			end
			default:
			begin
			end
		endcase
	end

	// ##################################################
	// Checks
	// ##################################################
	assert property (@(posedge CLK) disable iff (!nRST)
		!(ram_req.ren && ram_req.wen))
		else $error("RAM read and write requested together");

	assert property (@(posedge CLK) disable iff (!nRST)
		!(cache_rsp[0].ccwait && cache_rsp[1].ccwait))
		else $error("Both cores held in ccwait");

	// Busy states end only on a RAM completion or a snoop answer
	assert property (@(posedge CLK) disable iff (!nRST)
		state != IDLE |=> (state == $past(state)) || $past(access || snoop_ans))
		else $error("Controller left a busy state without ACCESS or snoop answer");

endmodule

// ==== source/coherence_bus_top.sv ====
// Two cores share one RAM. Caches live outside and hold each request until its wait falls
`timescale 1ns/100ps

module coherence_bus_top
	import coherence_pkg::*;
(
	input logic CLK,
	input logic nRST,
	input cache_req_t [1:0] cache_req,
	output cache_rsp_t [1:0] cache_rsp
);

	logic fetch_req;
	logic fetch_sel;
	logic fetch_done;
	ram_req_t ram_req;
	ramstate_t ramstate;
	word_t ramload;

	fetch_arbiter arb (
		.CLK(CLK),
		.nRST(nRST),
		.iren({cache_req[1].iren, cache_req[0].iren}),
		.fetch_done(fetch_done),
		.fetch_req(fetch_req),
		.fetch_sel(fetch_sel)
	);

	bus_controller ctrl (
		.CLK(CLK),
		.nRST(nRST),
		.cache_req(cache_req),
		.cache_rsp(cache_rsp),
		.fetch_req(fetch_req),
		.fetch_sel(fetch_sel),
		.fetch_done(fetch_done),
		.ram_req(ram_req),
		.ramstate(ramstate),
		.ramload(ramload)
	);

	memory_port ram (
		.CLK(CLK),
		.nRST(nRST),
		.ram_req(ram_req),
		.ramstate(ramstate),
		.ramload(ramload)
	);

endmodule

// ==== verif/coherence_bus_tb.sv ====
// Plays both cores' caches. Reads only addresses written earlier as the RAM has no reset contents
`timescale 1ns/100ps
`include "coherence_settings.svh"

module coherence_bus_tb
	import coherence_pkg::*;
();

	localparam int DEPTH = 1 << `RAM_DEPTH_LOG2;
	localparam int WORD_LEN = `RAM_LATENCY + 1;
	localparam int BLOCK_LEN = 2 * WORD_LEN + 3; // Decision, snoop answer, return to IDLE
	localparam int FETCH_LEN = WORD_LEN + 1;
	localparam int RESET_LEN = 10;
	localparam int LIMIT = 40 * (4 * BLOCK_LEN + 13 * FETCH_LEN + 2 * RESET_LEN);

	logic CLK;
	logic nRST;
	cache_req_t [1:0] req;
	cache_rsp_t [1:0] rsp;

	word_t shadow [DEPTH]; // Reference memory
	bit known [DEPTH];
	logic [31:0] lfsr = 32'h8ae0_ab12;
	int served [$]; // Core of each completed fetch
	int errors = 0;
	int tests = 0;
	int failed = 0;
	int cycles = 0;

	coherence_bus_top uut (
		.CLK(CLK),
		.nRST(nRST),
		.cache_req(req),
		.cache_rsp(rsp)
	);

	initial
	begin : clock_gen
		CLK = 1'b0;
		forever #2 CLK = ~CLK;
	end

	// ##################################################
	// Random numbers and reference model
	// ##################################################
	function automatic logic [31:0] next_lfsr(logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	function automatic logic [31:0] random_bits(int n);
		logic [31:0] v;
		v = '0;
		for (int k = 0; k < n; k++)
		begin
			lfsr = next_lfsr(lfsr); // One step per bit
			v = {v[30:0], lfsr[0]};
		end
		return v;
	endfunction

	function automatic word_t expected_word(addr_t a);
		return shadow[a[`RAM_DEPTH_LOG2-1:0]]; // RAM wraps at its depth
	endfunction

	function automatic void record_write(addr_t a, word_t w);
		shadow[a[`RAM_DEPTH_LOG2-1:0]] = w;
		known[a[`RAM_DEPTH_LOG2-1:0]] = 1'b1;
	endfunction

	function automatic void compare_word(string name, int c, addr_t a, word_t got);
		if (!known[a[`RAM_DEPTH_LOG2-1:0]])
		begin
			errors++;
			$display("Core %0d read address %h, which was never written", c, a);
		end
		else if (got !== expected_word(a))
		begin
			errors++;
			$display("ERROR %s core %0d addr %h: got %h, expected %h",
				name, c, a, got, expected_word(a));
		end
	endfunction

	function automatic void check_reset_outputs();
		for (int i = 0; i < 2; i++)
		begin
			if (rsp[i].iwait !== 1'b1 || rsp[i].dwait !== 1'b1 || rsp[i].ccwait !== 1'b0)
			begin
				errors++;
				$display("ERROR iwait/dwait/ccwait core %0d: got %h/%h/%h, expected 1/1/0",
					i, rsp[i].iwait, rsp[i].dwait, rsp[i].ccwait);
			end
		end
	endfunction

	function automatic void finish_test(string name, int start);
		tests++;
		if (errors != start)
			failed++;
		$display("Test %0d %s: %s, %0d errors", tests, name,
			(errors == start) ? "PASS" : "FAIL", errors - start);
	endfunction

	// Compares every word handed to a cache
	always @(posedge CLK)
	begin
		if (nRST)
		begin
			for (int i = 0; i < 2; i++)
			begin
				if (!rsp[i].iwait)
				begin
					served.push_back(i);
					compare_word("iload", i, req[i].iaddr, rsp[i].iload);
				end
				if (!rsp[i].dwait && req[i].dren)
					compare_word("dload", i, req[i].daddr, rsp[i].dload);
				if (rsp[i].ccinv !== req[1-i].ccwrite)
				begin
					errors++;
					$display("ERROR ccinv core %0d: got %h, expected %h",
						i, rsp[i].ccinv, req[1-i].ccwrite);
				end
			end
		end
	end

	// ##################################################
	// Cache behavior
	// ##################################################
	task automatic apply_reset();
		@(negedge CLK);
		nRST = 1'b0;
		repeat (8)
		begin
			@(posedge CLK);
			check_reset_outputs();
		end
		@(negedge CLK);
		nRST = 1'b1;
		repeat (2)
		begin
			@(posedge CLK);
			check_reset_outputs();
		end
	endtask

	task automatic wait_data(int c);
		@(posedge CLK);
		while (rsp[c].dwait)
			@(posedge CLK);
	endtask

	task automatic wait_fetch(int c);
		@(posedge CLK);
		while (rsp[c].iwait)
			@(posedge CLK);
	endtask

	task automatic write_back(int c, addr_t a, word_t w0, word_t w1);
		@(negedge CLK);
		req[c].dwen = 1'b1;
		req[c].daddr = a;
		req[c].dstore = w0;
		record_write(a, w0);
		wait_data(c);
		@(negedge CLK);
		req[c].daddr = a + 1;
		req[c].dstore = w1;
		record_write(a + 1, w1);
		wait_data(c);
		@(negedge CLK);
		req[c].dwen = 1'b0;
	endtask

	// Fetches alternate between the two words of a block
	task automatic fetch_block(int c, addr_t a, int n);
		for (int k = 0; k < n; k++)
		begin
			@(negedge CLK);
			req[c].iren = 1'b1;
			req[c].iaddr = a + k % 2;
			wait_fetch(c);
		end
		@(negedge CLK);
		req[c].iren = 1'b0;
	endtask

	task automatic snoop_read(int c, addr_t a);
		@(negedge CLK);
		req[c].cctrans = 1'b1;
		req[c].dren = 1'b1;
		req[c].daddr = a;
		wait_data(c);
		@(negedge CLK);
		req[c].daddr = a + 1;
		wait_data(c);
		@(negedge CLK);
		req[c].cctrans = 1'b0;
		req[c].dren = 1'b0;
	endtask

	task automatic snoop_answer(int c, addr_t a, logic dirty, word_t w0, word_t w1);
		@(posedge CLK);
		while (!rsp[c].ccwait)
			@(posedge CLK);
		if (rsp[c].ccsnoopaddr !== a)
		begin
			errors++;
			$display("ERROR ccsnoopaddr core %0d: got %h, expected %h",
				c, rsp[c].ccsnoopaddr, a);
		end
		@(negedge CLK);
		req[c].cctrans = 1'b1;
		req[c].ccwrite = dirty;
		req[c].daddr = a;
		req[c].dstore = w0;
		if (dirty)
		begin
			record_write(a, w0); // Owner data reaches RAM too
			wait_data(c);
			@(negedge CLK);
			req[c].daddr = a + 1;
			req[c].dstore = w1;
			record_write(a + 1, w1);
			wait_data(c);
		end
		else
		begin
			@(posedge CLK);
			while (rsp[c].ccwait)
				@(posedge CLK);
		end
		@(negedge CLK);
		req[c].cctrans = 1'b0;
		req[c].ccwrite = 1'b0;
	endtask

	// ##################################################
	// Test sequence
	// ##################################################
	initial
	begin : main
		addr_t blk_a;
		addr_t blk_b;
		addr_t blk_c;
		word_t w0;
		word_t w1;
		int start;
		req = '0;
		nRST = 1'b0;
		blk_a = random_bits(32);
		blk_b = random_bits(32);
		blk_c = random_bits(32);

		start = errors;
		apply_reset();
		finish_test("reset", start);

		start = errors;
		w0 = random_bits(32);
		w1 = random_bits(32);
		write_back(0, blk_a, w0, w1);
		fetch_block(1, blk_a, 2);
		finish_test("write-back then fetch", start);

		start = errors;
		fork
			snoop_read(1, blk_a);
			snoop_answer(0, blk_a, 1'b0, '0, '0);
		join
		finish_test("snoop with clean owner", start);

		start = errors;
		w0 = random_bits(32);
		w1 = random_bits(32);
		fork
			snoop_read(0, blk_b);
			snoop_answer(1, blk_b, 1'b1, w0, w1);
		join
		fetch_block(1, blk_b, 2); // RAM must hold the owner's words
		finish_test("cache-to-cache transfer", start);

		start = errors;
		apply_reset();
		served.delete();
		fork
			fetch_block(0, blk_a, 4);
			fetch_block(1, blk_b, 4);
		join
		if (served.size() != 8)
		begin
			errors++;
			$display("Round-robin saw %0d fetches instead of 8", served.size());
		end
		else
		begin
			for (int k = 0; k < 8; k++)
			begin
				if (served[k] != k % 2)
				begin
					errors++;
					$display("ERROR fetch_sel at fetch %0d: got %h, expected %h",
						k, served[k], k % 2);
				end
			end
		end
		finish_test("round-robin fetch", start);

		start = errors;
		w0 = random_bits(32);
		w1 = random_bits(32);
		fork
			write_back(0, blk_c, w0, w1);
			fetch_block(1, blk_c, 1);
			begin
				@(posedge CLK);
				while (rsp[0].dwait && rsp[1].iwait)
					@(posedge CLK);
				if (rsp[0].dwait)
				begin
					errors++;
					$display("Fetch of core 1 was served before the pending write-back");
				end
			end
		join
		finish_test("write-back over fetch priority", start);

		$display("%0d tests, %0d failed, %0d errors", tests, failed, errors);
		if (errors == 0)
			$display("Everything OK");
		else
			$display("Something failed");
		$finish;
	end

	initial
	begin : watchdog
		while (cycles < LIMIT)
		begin
			@(posedge CLK);
			cycles++;
		end
		$display("Tests did not finish within %0d cycles", LIMIT);
		$display("Something failed");
		$finish;
	end

endmodule

// ==== src.f ====
+incdir+include
source/coherence_pkg.sv
source/fetch_arbiter.sv
source/memory_port.sv
source/bus_controller.sv
source/coherence_bus_top.sv
verif/coherence_bus_tb.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS = --binary --timing --assert --timescale 1ns/100ps -j 0
TOP = coherence_bus_tb
FILELIST = src.f

OBJ_DIR = obj_dir
SIM = $(OBJ_DIR)/V$(TOP)
LOG = sim.log
SOURCES = $(shell grep -v '^+' $(FILELIST))
HEADERS = $(wildcard include/*.svh)

.PHONY: all run check clean

all: $(SIM)

# Rebuilt only when a source, a header or the file list changes
$(SIM): $(SOURCES) $(HEADERS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: $(SIM)
	./$(SIM) | tee $(LOG)

check: run
	@grep -q "Everything OK" $(LOG) && echo "Simulation passed" || \
		(echo "Simulation failed"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
